/* flist.f */
+incdir+logic
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/exec_if.sv
logic/fetch_buffer.sv
logic/inst_decoder.sv
logic/decode_stage.sv
logic/exec_stage.sv
logic/writeback_unit.sv
logic/core_top.sv
verification/core_asserts.sv
verification/core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the core testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f flist.f --top-module core_tb \
    -o core_sim; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "All tests passed!" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* verification/core_tb.sv */
`include "core_cfg.svh"

module core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_RAND     = 200;
  localparam int N_DIRECTED = 36;
  localparam int TOTAL_INST = N_DIRECTED + N_RAND;
  localparam int DRAIN_MAX  = 40;  // cycles allowed for the pipeline to empty at the end.

  logic                  clk;
  logic                  rst;
  logic                  inst_valid_i;
  logic                  inst_ready_o;
  logic [31:0]           inst_i;
  logic [`CORE_XLEN-1:0] pc_i;
  logic                  retire_valid_o;
  logic                  retire_ready_i;
  logic [`CORE_XLEN-1:0] retire_pc_o;
  logic [3:0]            retire_rd_o;
  logic                  retire_wen_o;
  logic                  retire_illegal_o;
  logic [`CORE_XLEN-1:0] retire_data_o;

  integer      seed;
  int          bp_mode;  // 0 ready, 1 random, 2 held low.
  int          sent_cnt;
  int          retired_cnt;
  logic [31:0] pc_next;
  logic [31:0] mregs [16];

  logic [31:0] q_pc [$];
  logic [3:0]  q_rd [$];
  logic        q_wen [$];
  logic        q_ill [$];
  logic [31:0] q_data [$];

  logic        take_q;
  logic        exp_avail;
  logic [31:0] exp_pc;
  logic [3:0]  exp_rd;
  logic        exp_wen;
  logic        exp_ill;
  logic [31:0] exp_data;

  core_top dut0 (.*);

  bind core_top core_asserts asrt0 (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "run stopped");
  endtask

  task automatic report_mismatch(input string what);
    $display("Mismatch at %0t: retire %s differs from the model", $time, what);
    $display("Test failures found");
    $fatal(1, "run stopped");
  endtask

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  // two's complement order: a sign difference decides, else the unsigned order.
  function automatic logic [31:0] less_signed(input logic [31:0] x, input logic [31:0] y);
    if (x[31] != y[31]) return {31'd0, x[31]};
    return {31'd0, x < y};
  endfunction

  // logical shift with the vacated top bits filled from the sign.
  function automatic logic [31:0] shift_right_arith(input logic [31:0] v,
                                                    input logic [4:0] sh);
    logic [31:0] fill;
    fill = v[31] ? ~(32'hffff_ffff >> sh) : 32'd0;
    return (v >> sh) | fill;
  endfunction

  // applies one instruction to the model in program order.
  task automatic model_accept(input logic [31:0] ins, input logic [31:0] pc);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [4:0]  rd;
    logic [4:0]  s1;
    logic [4:0]  s2;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic        ill;
    logic        wen;
    opc = ins[6:0];
    f3  = ins[14:12];
    f7  = ins[31:25];
    rd  = ins[11:7];
    s1  = ins[19:15];
    s2  = ins[24:20];
    a   = (s1[4] || s1 == 5'd0) ? 32'd0 : mregs[s1[3:0]];
    b   = (s2[4] || s2 == 5'd0) ? 32'd0 : mregs[s2[3:0]];
    res = 32'd0;
    ill = rd[4];
    case (opc)
      7'b0110111: res = {ins[31:12], 12'b0};
      7'b0010111: res = pc + {ins[31:12], 12'b0};
      7'b0010011: begin
        b   = {{20{ins[31]}}, ins[31:20]};
        ill = ill || s1[4];
        case (f3)
          3'd0: res = a + b;
          3'd2: res = less_signed(a, b);
          3'd4: res = a ^ b;
          3'd6: res = a | b;
          3'd7: res = a & b;
          3'd1: begin
            res = a << b[4:0];
            ill = ill || f7 != 7'h00;
          end
          3'd5: begin
            res = (f7 == 7'h20) ? shift_right_arith(a, b[4:0]) : a >> b[4:0];
            ill = ill || (f7 != 7'h00 && f7 != 7'h20);
          end
          default: ill = 1'b1;
        endcase
      end
      7'b0110011: begin
        ill = ill || s1[4] || s2[4];
        case ({f7, f3})
          {7'h00, 3'd0}: res = a + b;
          {7'h20, 3'd0}: res = a - b;
          {7'h00, 3'd1}: res = a << b[4:0];
          {7'h00, 3'd2}: res = less_signed(a, b);
          {7'h00, 3'd4}: res = a ^ b;
          {7'h00, 3'd5}: res = a >> b[4:0];
          {7'h20, 3'd5}: res = shift_right_arith(a, b[4:0]);
          {7'h00, 3'd6}: res = a | b;
          {7'h00, 3'd7}: res = a & b;
          default:       ill = 1'b1;
        endcase
      end
      default: ill = 1'b1;
    endcase
    wen = !ill && rd != 5'd0;
    if (wen) mregs[rd[3:0]] = res;
    q_pc.push_back(pc);
    q_rd.push_back(rd[3:0]);
    q_wen.push_back(wen);
    q_ill.push_back(ill);
    q_data.push_back(res);
  endtask

  // inputs are stable from +1ns, so handshakes are seen at the falling edge.
  always @(negedge clk) begin
    if (take_q && q_pc.size() != 0) begin
      void'(q_pc.pop_front());
      void'(q_rd.pop_front());
      void'(q_wen.pop_front());
      void'(q_ill.pop_front());
      void'(q_data.pop_front());
      retired_cnt++;
    end
    if (!rst && inst_valid_i && inst_ready_o) model_accept(inst_i, pc_i);
    exp_avail = q_pc.size() != 0;
    if (exp_avail) begin
      exp_pc   = q_pc[0];
      exp_rd   = q_rd[0];
      exp_wen  = q_wen[0];
      exp_ill  = q_ill[0];
      exp_data = q_data[0];
    end
    take_q = !rst && retire_valid_o && retire_ready_i;
  end

  retire_expected: assert property (@(posedge clk) disable iff (rst)
    retire_valid_o && retire_ready_i |-> exp_avail)
    else fail_run("an instruction retired that was never sent");
  pc_check: assert property (@(posedge clk) disable iff (rst)
    retire_valid_o && retire_ready_i && exp_avail |-> retire_pc_o == exp_pc)
    else report_mismatch("pc");
  flag_check: assert property (@(posedge clk) disable iff (rst)
    retire_valid_o && retire_ready_i && exp_avail |->
      retire_illegal_o == exp_ill && retire_wen_o == exp_wen)
    else report_mismatch("illegal or wen flag");
  rd_check: assert property (@(posedge clk) disable iff (rst)
    retire_valid_o && retire_ready_i && exp_avail && !exp_ill |-> retire_rd_o == exp_rd)
    else report_mismatch("rd");
  data_check: assert property (@(posedge clk) disable iff (rst)
    retire_valid_o && retire_ready_i && exp_avail && !exp_ill |->
      retire_data_o == exp_data)
    else report_mismatch("data");

  initial begin
    forever begin
      @(posedge clk);
      #2;
      case (bp_mode)
        1:       retire_ready_i = ($random(seed) & 3) != 0;
        2:       retire_ready_i = 1'b0;
        default: retire_ready_i = 1'b1;
      endcase
    end
  end

  task automatic send(input logic [31:0] ins);
    logic took;
    inst_valid_i = 1'b1;
    inst_i       = ins;
    pc_i         = pc_next;
    do begin
      @(negedge clk);
      took = inst_ready_o;
      @(posedge clk);
      #1;
    end while (!took);
    inst_valid_i = 1'b0;
    pc_next      = pc_next + 32'd4;
    sent_cnt++;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  function automatic logic [31:0] random_inst(input logic [31:0] r, input logic [31:0] s);
    case (r[2:0])
      3'd0:    return u_type(s[19:0], {1'b0, s[23:20]}, 7'b0110111);
      3'd1:    return u_type(s[19:0], {1'b0, s[23:20]}, 7'b0010111);
      3'd2, 3'd3: begin
        if (r[13:12] == 2'b01) return {1'b0, r[8], 5'd0, s[4:0], 1'b0, s[11:8], 3'b101,
                                       1'b0, s[15:12], 7'b0010011};
        return i_type(s[31:20], r[14:12], {1'b0, s[15:12]}, {1'b0, s[11:8]});
      end
      3'd7:    return s;  // mostly undefined.
      default: return r_type({1'b0, r[8], 5'd0}, r[14:12], {1'b0, s[3:0]},
                             {1'b0, s[7:4]}, {1'b0, s[11:8]});
    endcase
  endfunction

  initial begin
    logic [31:0] r;
    logic [31:0] s;
    seed           = 32'h3a07_de19;
    rst            = 1'b1;
    inst_valid_i   = 1'b0;
    inst_i         = '0;
    pc_i           = '0;
    retire_ready_i = 1'b1;
    bp_mode        = 0;
    sent_cnt       = 0;
    retired_cnt    = 0;
    take_q         = 1'b0;
    exp_avail      = 1'b0;
    pc_next        = 32'h0000_1000;
    for (int i = 0; i < 16; i++) mregs[i] = '0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    // every alu operation, lui, auipc and signed compares.
    send(u_type(20'h12345, 5'd1, 7'b0110111));
    send(i_type(12'h678, 3'd0, 5'd1, 5'd1));
    send(i_type(12'hffb, 3'd0, 5'd2, 5'd0));
    send(u_type(20'h00001, 5'd3, 7'b0010111));
    send(r_type(7'h00, 3'd0, 5'd4, 5'd1, 5'd2));
    send(r_type(7'h20, 3'd0, 5'd5, 5'd1, 5'd2));
    send(r_type(7'h00, 3'd2, 5'd6, 5'd2, 5'd1));
    send(r_type(7'h00, 3'd2, 5'd7, 5'd1, 5'd2));
    send(r_type(7'h00, 3'd4, 5'd4, 5'd1, 5'd3));
    send(r_type(7'h00, 3'd6, 5'd5, 5'd1, 5'd2));
    send(r_type(7'h00, 3'd7, 5'd6, 5'd1, 5'd2));
    send(r_type(7'h00, 3'd1, 5'd7, 5'd1, 5'd6));
    send(r_type(7'h00, 3'd5, 5'd4, 5'd2, 5'd6));
    send(r_type(7'h20, 3'd5, 5'd5, 5'd2, 5'd6));
    send(i_type(12'h001, 3'd2, 5'd6, 5'd2));
    send(i_type(12'h0f0, 3'd4, 5'd7, 5'd1));
    send(i_type(12'h800, 3'd6, 5'd4, 5'd1));
    send(i_type(12'h0ff, 3'd7, 5'd5, 5'd1));
    send(i_type(12'h004, 3'd1, 5'd6, 5'd1));
    send(i_type(12'h008, 3'd5, 5'd7, 5'd2));
    send(i_type(12'h408, 3'd5, 5'd4, 5'd2));
    // back-to-back dependencies through forwarding.
    send(i_type(12'h007, 3'd0, 5'd8, 5'd0));
    send(r_type(7'h00, 3'd0, 5'd9, 5'd8, 5'd8));
    send(r_type(7'h20, 3'd0, 5'd10, 5'd9, 5'd8));
    // the consumer stalls while its producer is parked in writeback.
    idle(8);
    bp_mode = 2;
    send(i_type(12'h064, 3'd0, 5'd11, 5'd0));
    send(i_type(12'h001, 3'd0, 5'd12, 5'd11));
    send(r_type(7'h00, 3'd0, 5'd13, 5'd11, 5'd12));
    idle(10);
    bp_mode = 0;
    // x0 stays zero.
    send(i_type(12'h005, 3'd0, 5'd0, 5'd1));
    send(r_type(7'h00, 3'd0, 5'd14, 5'd0, 5'd0));
    send(i_type(12'h003, 3'd0, 5'd15, 5'd0));
    // undefined encodings.
    send(32'hffff_ffff);
    send(i_type(12'h001, 3'd3, 5'd3, 5'd1));
    send(r_type(7'h01, 3'd0, 5'd3, 5'd1, 5'd2));
    send(i_type(12'h001, 3'd0, 5'd16, 5'd1));
    send(r_type(7'h00, 3'd0, 5'd3, 5'd17, 5'd2));
    send(r_type(7'h00, 3'd0, 5'd9, 5'd3, 5'd3));

    bp_mode = 1;
    for (int n = 0; n < N_RAND; n++) begin
      r = $random(seed);
      s = $random(seed);
      idle(r[31:30]);
      send(random_inst(r, s));
    end
    bp_mode = 0;

    for (int c = 0; c < DRAIN_MAX && q_pc.size() != 0; c++) @(posedge clk);
    repeat (4) @(posedge clk);
    if (retired_cnt == sent_cnt && q_pc.size() == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("retired %0d of %0d instructions", retired_cnt, sent_cnt);
      $display("Test failures found");
      $fatal(1, "run stopped");
    end
  end

  initial begin
    #((TOTAL_INST * 40 + 16) * 100);
    fail_run("timeout, the pipeline stopped retiring instructions");
  end

endmodule

/* verification/core_asserts.sv */
`include "core_cfg.svh"

module core_asserts (
  input logic                  clk,
  input logic                  rst,
  input logic                  retire_valid_o,
  input logic                  retire_ready_i,
  input logic [`CORE_XLEN-1:0] retire_pc_o,
  input pipe_pkg::reg_idx_t    retire_rd_o,
  input logic                  retire_wen_o,
  input logic                  retire_illegal_o,
  input logic [`CORE_XLEN-1:0] retire_data_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // the retire register is cleared by reset.
  reset_clears_retire: assert property (@(posedge clk) rst |=> !retire_valid_o)
    else $error("retire_valid_o high after a reset edge");

  // a stalled retire keeps its content until taken.
  hold_valid: assert property (@(posedge clk) disable iff (rst)
    retire_valid_o && !retire_ready_i |=> retire_valid_o)
    else $error("retire_valid_o dropped before the handshake");

  hold_payload: assert property (@(posedge clk) disable iff (rst)
    retire_valid_o && !retire_ready_i |=>
      $stable(retire_pc_o) && $stable(retire_rd_o) && $stable(retire_wen_o) &&
      $stable(retire_illegal_o) && $stable(retire_data_o))
    else $error("retire payload changed while back-pressured");

  no_x0_write: assert property (@(posedge clk) disable iff (rst)
    retire_valid_o |-> !(retire_wen_o && retire_rd_o == '0))
    else $error("write enable set for x0");

  illegal_no_write: assert property (@(posedge clk) disable iff (rst)
    retire_valid_o && retire_illegal_o |-> !retire_wen_o)
    else $error("illegal instruction retired with write enable");

endmodule

/* logic/core_top.sv */
`include "core_cfg.svh"

module core_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  inst_valid_i,
  output logic                  inst_ready_o,
  input  logic [31:0]           inst_i,
  input  logic [`CORE_XLEN-1:0] pc_i,
  output logic                  retire_valid_o,
  input  logic                  retire_ready_i,
  output logic [`CORE_XLEN-1:0] retire_pc_o,
  output pipe_pkg::reg_idx_t    retire_rd_o,
  output logic                  retire_wen_o,
  output logic                  retire_illegal_o,
  output logic [`CORE_XLEN-1:0] retire_data_o
);
  import pipe_pkg::*;

  logic                   fb_valid;
  logic                   fb_ready;
  logic [31:0]            fb_inst;
  logic [`CORE_XLEN-1:0]  fb_pc;

  reg_idx_t               rs1;
  reg_idx_t               rs2;
  logic [`CORE_XLEN-1:0]  rdata1;
  logic [`CORE_XLEN-1:0]  rdata2;
  logic [`CORE_NREGS-1:0] pending_mask;

  logic                   ex_valid;
  logic                   ex_ready;
  logic [`CORE_XLEN-1:0]  ex_pc;
  reg_idx_t               ex_rd;
  logic                   ex_wen;
  logic                   ex_illegal;
  logic [`CORE_XLEN-1:0]  ex_result;

  exec_if ex_bus ();

  fetch_buffer u_fetch (
    .clk          (clk),
    .rst          (rst),
    .inst_valid_i (inst_valid_i),
    .inst_ready_o (inst_ready_o),
    .inst_i       (inst_i),
    .pc_i         (pc_i),
    .fb_valid_o   (fb_valid),
    .fb_ready_i   (fb_ready),
    .fb_inst_o    (fb_inst),
    .fb_pc_o      (fb_pc)
  );

  decode_stage u_decode (
    .clk            (clk),
    .rst            (rst),
    .fb_valid_i     (fb_valid),
    .fb_ready_o     (fb_ready),
    .fb_inst_i      (fb_inst),
    .fb_pc_i        (fb_pc),
    .rs1_o          (rs1),
    .rs2_o          (rs2),
    .rdata1_i       (rdata1),
    .rdata2_i       (rdata2),
    .pending_mask_i (pending_mask),
    .ex_valid_i     (ex_valid),
    .ex_wen_i       (ex_wen),
    .ex_rd_i        (ex_rd),
    .ex_result_i    (ex_result),
    .ex_bus         (ex_bus.out)
  );

  exec_stage u_exec (
    .clk          (clk),
    .rst          (rst),
    .ex_bus       (ex_bus.in),
    .ex_valid_o   (ex_valid),
    .ex_ready_i   (ex_ready),
    .ex_pc_o      (ex_pc),
    .ex_rd_o      (ex_rd),
    .ex_wen_o     (ex_wen),
    .ex_illegal_o (ex_illegal),
    .ex_result_o  (ex_result)
  );

  writeback_unit u_wb (
    .clk              (clk),
    .rst              (rst),
    .ex_valid_i       (ex_valid),
    .ex_ready_o       (ex_ready),
    .ex_pc_i          (ex_pc),
    .ex_rd_i          (ex_rd),
    .ex_wen_i         (ex_wen),
    .ex_illegal_i     (ex_illegal),
    .ex_result_i      (ex_result),
    .rs1_i            (rs1),
    .rs2_i            (rs2),
    .rdata1_o         (rdata1),
    .rdata2_o         (rdata2),
    .pending_mask_o   (pending_mask),
    .retire_valid_o   (retire_valid_o),
    .retire_ready_i   (retire_ready_i),
    .retire_pc_o      (retire_pc_o),
    .retire_rd_o      (retire_rd_o),
    .retire_wen_o     (retire_wen_o),
    .retire_illegal_o (retire_illegal_o),
    .retire_data_o    (retire_data_o)
  );

endmodule

/* logic/writeback_unit.sv */
`include "core_cfg.svh"

module writeback_unit (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   ex_valid_i,
  output logic                   ex_ready_o,
  input  logic [`CORE_XLEN-1:0]  ex_pc_i,
  input  pipe_pkg::reg_idx_t     ex_rd_i,
  input  logic                   ex_wen_i,
  input  logic                   ex_illegal_i,
  input  logic [`CORE_XLEN-1:0]  ex_result_i,
  input  pipe_pkg::reg_idx_t     rs1_i,
  input  pipe_pkg::reg_idx_t     rs2_i,
  output logic [`CORE_XLEN-1:0]  rdata1_o,
  output logic [`CORE_XLEN-1:0]  rdata2_o,
  output logic [`CORE_NREGS-1:0] pending_mask_o,
  output logic                   retire_valid_o,
  input  logic                   retire_ready_i,
  output logic [`CORE_XLEN-1:0]  retire_pc_o,
  output pipe_pkg::reg_idx_t     retire_rd_o,
  output logic                   retire_wen_o,
  output logic                   retire_illegal_o,
  output logic [`CORE_XLEN-1:0]  retire_data_o
);
  import pipe_pkg::*;

  logic                  valid_q;
  logic [`CORE_XLEN-1:0] pc_q;
  reg_idx_t              rd_q;
  logic                  wen_q;
  logic                  illegal_q;
  logic [`CORE_XLEN-1:0] data_q;
  logic                  retire;

  logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];

  assign retire     = valid_q && retire_ready_i;
  assign ex_ready_o = !valid_q || retire_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (ex_ready_o) begin
      valid_q <= ex_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid_i && ex_ready_o) begin
      pc_q      <= ex_pc_i;
      rd_q      <= ex_rd_i;
      wen_q     <= ex_wen_i;
      illegal_q <= ex_illegal_i;
      data_q    <= ex_result_i;
    end
  end

  // register file is committed on the retire handshake only.
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `CORE_NREGS; i++) regs[i] <= '0;
    end else if (retire && wen_q && rd_q != '0) begin
      regs[rd_q] <= data_q;
    end
  end

  assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

  always_comb begin
    pending_mask_o = '0;
    if (valid_q && wen_q) pending_mask_o[rd_q] = 1'b1;
  end

  assign retire_valid_o   = valid_q;
  assign retire_pc_o      = pc_q;
  assign retire_rd_o      = rd_q;
  assign retire_wen_o     = wen_q;
  assign retire_illegal_o = illegal_q;
  assign retire_data_o    = data_q;

endmodule

/* logic/exec_stage.sv */
`include "core_cfg.svh"

module exec_stage (
  input  logic                  clk,
  input  logic                  rst,
  exec_if.in                    ex_bus,
  output logic                  ex_valid_o,
  input  logic                  ex_ready_i,
  output logic [`CORE_XLEN-1:0] ex_pc_o,
  output pipe_pkg::reg_idx_t    ex_rd_o,
  output logic                  ex_wen_o,
  output logic                  ex_illegal_o,
  output logic [`CORE_XLEN-1:0] ex_result_o
);
  import isa_pkg::*;
  import pipe_pkg::*;

  logic [`CORE_XLEN-1:0] a;
  logic [`CORE_XLEN-1:0] b;
  logic [4:0]            shamt;
  logic [`CORE_XLEN-1:0] alu_res;

  logic                  valid_q;
  logic [`CORE_XLEN-1:0] pc_q;
  reg_idx_t              rd_q;
  logic                  wen_q;
  logic                  illegal_q;
  logic [`CORE_XLEN-1:0] result_q;

  assign a     = ex_bus.op.op1;
  assign b     = ex_bus.op.op2;
  assign shamt = b[4:0];

  always_comb begin
    case (ex_bus.op.alu_op)
      ALU_ADD:   alu_res = a + b;
      ALU_SUB:   alu_res = a - b;
      ALU_SLT:   alu_res = {{(`CORE_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      ALU_XOR:   alu_res = a ^ b;
      ALU_OR:    alu_res = a | b;
      ALU_AND:   alu_res = a & b;
      ALU_SLL:   alu_res = a << shamt;
      ALU_SRL:   alu_res = a >> shamt;
      ALU_SRA:   alu_res = $unsigned($signed(a) >>> shamt);
      ALU_PASS2: alu_res = b;
      default:   alu_res = '0;
    endcase
  end

  assign ex_bus.ready = !valid_q || ex_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (ex_bus.ready) begin
      valid_q <= ex_bus.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_bus.valid && ex_bus.ready) begin
      pc_q      <= ex_bus.op.pc;
      rd_q      <= ex_bus.op.rd;
      wen_q     <= ex_bus.op.wen;
      illegal_q <= ex_bus.op.illegal;
      result_q  <= alu_res;
    end
  end

  // also read by decode for forwarding.
  assign ex_valid_o   = valid_q;
  assign ex_pc_o      = pc_q;
  assign ex_rd_o      = rd_q;
  assign ex_wen_o     = wen_q;
  assign ex_illegal_o = illegal_q;
  assign ex_result_o  = result_q;

endmodule

/* logic/decode_stage.sv */
`include "core_cfg.svh"

module decode_stage (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   fb_valid_i,
  output logic                   fb_ready_o,
  input  logic [31:0]            fb_inst_i,
  input  logic [`CORE_XLEN-1:0]  fb_pc_i,
  output pipe_pkg::reg_idx_t     rs1_o,
  output pipe_pkg::reg_idx_t     rs2_o,
  input  logic [`CORE_XLEN-1:0]  rdata1_i,
  input  logic [`CORE_XLEN-1:0]  rdata2_i,
  input  logic [`CORE_NREGS-1:0] pending_mask_i,
  input  logic                   ex_valid_i,
  input  logic                   ex_wen_i,
  input  pipe_pkg::reg_idx_t     ex_rd_i,
  input  logic [`CORE_XLEN-1:0]  ex_result_i,
  exec_if.out                    ex_bus
);
  import isa_pkg::*;
  import pipe_pkg::*;

  logic                  valid_q;
  logic [31:0]           inst_q;
  logic [`CORE_XLEN-1:0] pc_q;

  reg_idx_t              rs1;
  reg_idx_t              rs2;
  logic                  use_rs1;
  logic                  use_rs2;
  logic                  fwd1;
  logic                  fwd2;
  logic                  stall;
  logic [`CORE_XLEN-1:0] rs1_val;
  logic [`CORE_XLEN-1:0] rs2_val;

  assign rs1   = inst_q[18:15];
  assign rs2   = inst_q[23:20];
  assign rs1_o = rs1;
  assign rs2_o = rs2;

  // lui and auipc read nothing, op-imm reads rs1 only.
  assign use_rs1 = (inst_q[6:0] == OP_IMM || inst_q[6:0] == OP_REG) && rs1 != '0;
  assign use_rs2 = (inst_q[6:0] == OP_REG) && rs2 != '0;

  // execute holds the youngest write, so it wins over writeback.
  assign fwd1 = ex_valid_i && ex_wen_i && ex_rd_i == rs1;
  assign fwd2 = ex_valid_i && ex_wen_i && ex_rd_i == rs2;

  assign stall = (use_rs1 && pending_mask_i[rs1] && !fwd1) ||
                 (use_rs2 && pending_mask_i[rs2] && !fwd2);

  assign rs1_val = fwd1 ? ex_result_i : rdata1_i;  // file returns zero for x0.
  assign rs2_val = fwd2 ? ex_result_i : rdata2_i;

  assign ex_bus.valid = valid_q && !stall;
  assign fb_ready_o   = !valid_q || (ex_bus.valid && ex_bus.ready);

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (fb_ready_o) begin
      valid_q <= fb_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (fb_valid_i && fb_ready_o) begin
      inst_q <= fb_inst_i;
      pc_q   <= fb_pc_i;
    end
  end

  inst_decoder u_decoder (
    .inst_i (inst_q),
    .pc_i   (pc_q),
    .rs1v_i (rs1_val),
    .rs2v_i (rs2_val),
    .op_o   (ex_bus.op)
  );

endmodule

/* logic/inst_decoder.sv */
`include "core_cfg.svh"

module inst_decoder (
  input  logic [31:0]           inst_i,
  input  logic [`CORE_XLEN-1:0] pc_i,
  input  logic [`CORE_XLEN-1:0] rs1v_i,
  input  logic [`CORE_XLEN-1:0] rs2v_i,
  output pipe_pkg::dec_op_t     op_o
);
  import isa_pkg::*;

  logic [6:0]            funct7;
  funct3_e               funct3;
  logic [`CORE_XLEN-1:0] imm_i;
  logic [`CORE_XLEN-1:0] imm_u;
  logic                  hi_reg;  // register field above x15.

  assign funct7 = inst_i[31:25];
  assign funct3 = funct3_e'(inst_i[14:12]);
  assign imm_i  = {{(`CORE_XLEN-12){inst_i[31]}}, inst_i[31:20]};
  assign imm_u  = {inst_i[31:12], 12'b0};

  always_comb begin
    op_o.pc      = pc_i;
    op_o.op1     = rs1v_i;
    op_o.op2     = rs2v_i;
    op_o.alu_op  = ALU_ADD;
    op_o.rd      = inst_i[10:7];
    op_o.wen     = 1'b1;
    op_o.illegal = 1'b0;
    hi_reg       = inst_i[11];
    case (inst_i[6:0])
      OP_LUI: begin
        op_o.op1    = '0;
        op_o.op2    = imm_u;
        op_o.alu_op = ALU_PASS2;
      end
      OP_AUIPC: begin
        op_o.op1 = pc_i;
        op_o.op2 = imm_u;
      end
      OP_IMM: begin
        op_o.op2 = imm_i;
        hi_reg   = inst_i[11] || inst_i[19];
        case (funct3)
          F3_ADD:  op_o.alu_op = ALU_ADD;
          F3_SLT:  op_o.alu_op = ALU_SLT;
          F3_XOR:  op_o.alu_op = ALU_XOR;
          F3_OR:   op_o.alu_op = ALU_OR;
          F3_AND:  op_o.alu_op = ALU_AND;
          F3_SLL: begin
            op_o.alu_op  = ALU_SLL;
            op_o.illegal = (funct7 != F7_BASE);
          end
          F3_SR: begin
            op_o.alu_op  = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
            op_o.illegal = (funct7 != F7_BASE) && (funct7 != F7_ALT);
          end
          default: op_o.illegal = 1'b1;  // sltiu.
        endcase
      end
      OP_REG: begin
        hi_reg = inst_i[11] || inst_i[19] || inst_i[24];
        if (funct7 == F7_BASE) begin
          case (funct3)
            F3_ADD:  op_o.alu_op = ALU_ADD;
            F3_SLL:  op_o.alu_op = ALU_SLL;
            F3_SLT:  op_o.alu_op = ALU_SLT;
            F3_XOR:  op_o.alu_op = ALU_XOR;
            F3_SR:   op_o.alu_op = ALU_SRL;
            F3_OR:   op_o.alu_op = ALU_OR;
            F3_AND:  op_o.alu_op = ALU_AND;
            default: op_o.illegal = 1'b1;
          endcase
        end else if (funct7 == F7_ALT && funct3 == F3_ADD) begin
          op_o.alu_op = ALU_SUB;
        end else if (funct7 == F7_ALT && funct3 == F3_SR) begin
          op_o.alu_op = ALU_SRA;
        end else begin
          op_o.illegal = 1'b1;
        end
      end
      default: op_o.illegal = 1'b1;
    endcase
    if (hi_reg) op_o.illegal = 1'b1;  // rv32e has x0..x15 only.
    // nothing is written for illegal ops or x0.
    if (op_o.illegal || op_o.rd == '0) op_o.wen = 1'b0;
  end

endmodule

/* logic/fetch_buffer.sv */
`include "core_cfg.svh"

module fetch_buffer (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  inst_valid_i,
  output logic                  inst_ready_o,
  input  logic [31:0]           inst_i,
  input  logic [`CORE_XLEN-1:0] pc_i,
  output logic                  fb_valid_o,
  input  logic                  fb_ready_i,
  output logic [31:0]           fb_inst_o,
  output logic [`CORE_XLEN-1:0] fb_pc_o
);

  logic                  valid_q;
  logic [31:0]           inst_q;
  logic [`CORE_XLEN-1:0] pc_q;

  // free when empty or draining this cycle.
  assign inst_ready_o = !valid_q || fb_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (inst_ready_o) begin
      valid_q <= inst_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (inst_valid_i && inst_ready_o) begin
      inst_q <= inst_i;
      pc_q   <= pc_i;
    end
  end

  assign fb_valid_o = valid_q;
  assign fb_inst_o  = inst_q;
  assign fb_pc_o    = pc_q;

endmodule

/* logic/exec_if.sv */
interface exec_if;
  import pipe_pkg::*;

  logic    valid;
  logic    ready;
  dec_op_t op;

  // decode side.
  modport out (
    output valid,
    output op,
    input  ready
  );

  // execute side.
  modport in (
    input  valid,
    input  op,
    output ready
  );

endinterface

/* logic/pipe_pkg.sv */
`include "core_cfg.svh"

package pipe_pkg;

  typedef logic [$clog2(`CORE_NREGS)-1:0] reg_idx_t;

  // one instruction after decode, operands already resolved.
  typedef struct packed {
    logic [`CORE_XLEN-1:0] pc;
    logic [`CORE_XLEN-1:0] op1;
    logic [`CORE_XLEN-1:0] op2;
    isa_pkg::alu_op_e      alu_op;
    reg_idx_t              rd;
    logic                  wen;
    logic                  illegal;
  } dec_op_t;

endpackage

/* logic/isa_pkg.sv */
package isa_pkg;

  // major opcodes of the supported subset.
  typedef enum logic [6:0] {
    OP_LUI   = 7'b0110111,
    OP_AUIPC = 7'b0010111,
    OP_IMM   = 7'b0010011,
    OP_REG   = 7'b0110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD   = 4'd0,
    ALU_SUB   = 4'd1,
    ALU_SLT   = 4'd2,
    ALU_XOR   = 4'd3,
    ALU_OR    = 4'd4,
    ALU_AND   = 4'd5,
    ALU_SLL   = 4'd6,
    ALU_SRL   = 4'd7,
    ALU_SRA   = 4'd8,
    ALU_PASS2 = 4'd9  // result is op2, used by lui.
  } alu_op_e;

  typedef enum logic [2:0] {
    F3_ADD  = 3'b000,
    F3_SLL  = 3'b001,
    F3_SLT  = 3'b010,
    F3_SLTU = 3'b011,  // not in the subset.
    F3_XOR  = 3'b100,
    F3_SR   = 3'b101,
    F3_OR   = 3'b110,
    F3_AND  = 3'b111
  } funct3_e;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub and sra.

endpackage

/* logic/core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// architectural data width.
`define CORE_XLEN 32

// rv32e register count.
`define CORE_NREGS 16

`endif
